// File: map_consts.svh
`ifndef MAP_CONSTS_SVH
`define MAP_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~ Mapper numbers
`define MAP_NROM 8'd0
`define MAP_UXROM 8'd2
`define MAP_AXROM 8'd7
`define MAP_GXROM 8'd66

// ~~~~~~~~~~~~~~~~~~~~ Physical address widths
`define PRG_AW 19 // 512K PRG-ROM
`define CHR_AW 17 // 128K CHR space

// Last 16K bank of a 512K UxROM image
`define UX_LAST_BANK 5'd31

`endif

// File: map_pkg.sv
package map_pkg;

`include "map_consts.svh"

	// CPU side
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0] cpu_data_t;

	// PPU side
	typedef logic [13:0] ppu_addr_t;

	typedef logic [7:0] map_idx_t; // Mapper number from config

	// Physical cartridge addresses
	typedef logic [`PRG_AW-1:0] prg_addr_t;
	typedef logic [`CHR_AW-1:0] chr_addr_t;

endpackage

// File: bus_decode.sv
`timescale 1ns/1ps

module bus_decode import map_pkg::*; (
	input logic clk,
	input logic rst,
	input cpu_addr_t cpu_addr,
	input cpu_data_t cpu_data,
	input logic cpu_we,
	input ppu_addr_t ppu_addr,
	output logic reg_wr,
	output cpu_data_t reg_data,
	output cpu_addr_t cpu_addr_q,
	output ppu_addr_t ppu_addr_q
);

	logic we_q; // Write strobe aligned with cpu_addr_q
	cpu_data_t data_q;

	// ~~~~~~~~~~~~~~~~~~~~ Bus sampling
	always_ff @(posedge clk) begin
		if (rst) begin
			cpu_addr_q <= '0;
			ppu_addr_q <= '0;
			we_q <= 1'b0;
		end else begin
			cpu_addr_q <= cpu_addr;
			ppu_addr_q <= ppu_addr;
			we_q <= cpu_we;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~ Register write pulse
	// Only writes into $8000-$FFFF reach the bank registers
	always_ff @(posedge clk) begin
		if (rst) begin
			reg_wr <= 1'b0;
		end else begin
			reg_wr <= we_q & cpu_addr_q[15]; // ROM area write
		end
	end

	always_ff @(posedge clk) begin
		data_q <= cpu_data;
		reg_data <= data_q; // Byte travels with reg_wr
	end

endmodule

// File: map_002.sv
`timescale 1ns/1ps

`include "map_consts.svh"

module map_002 import map_pkg::*; (
	input logic clk,
	input logic rst,
	input logic reg_wr,
	input cpu_data_t reg_data,
	input cpu_addr_t cpu_addr_q,
	input ppu_addr_t ppu_addr_q,
	input logic mirror_v,
	output prg_addr_t prg_addr,
	output chr_addr_t chr_addr,
	output logic ciram_a10
);

	logic [4:0] prg_bank; // Switchable 16K bank at $8000

	always_ff @(posedge clk) begin
		if (rst) begin
			prg_bank <= '0;
		end else if (reg_wr) begin
			prg_bank <= reg_data[4:0];
		end
	end

	always_comb begin
		if (!cpu_addr_q[14]) begin
			prg_addr = prg_addr_t'({prg_bank, cpu_addr_q[13:0]});
		end else begin
			prg_addr = prg_addr_t'({`UX_LAST_BANK, cpu_addr_q[13:0]}); // $C000 window
		end
	end

	// 8K CHR-RAM, no banking
	assign chr_addr = chr_addr_t'(ppu_addr_q[12:0]);
	assign ciram_a10 = mirror_v ? ppu_addr_q[10] : ppu_addr_q[11];

endmodule

// File: map_007.sv
`timescale 1ns/1ps

module map_007 import map_pkg::*; (
	input logic clk,
	input logic rst,
	input logic reg_wr,
	input cpu_data_t reg_data,
	input cpu_addr_t cpu_addr_q,
	input ppu_addr_t ppu_addr_q,
	output prg_addr_t prg_addr,
	output chr_addr_t chr_addr,
	output logic ciram_a10
);

	logic [2:0] prg_bank; // 32K bank
	logic one_scr; // Nametable page select

	always_ff @(posedge clk) begin
		if (rst) begin
			prg_bank <= '0;
			one_scr <= 1'b0;
		end else if (reg_wr) begin
			prg_bank <= reg_data[2:0];
			one_scr <= reg_data[4];
		end
	end

	// Whole $8000-$FFFF window switches at once
	assign prg_addr = prg_addr_t'({prg_bank, cpu_addr_q[14:0]});

	assign chr_addr = chr_addr_t'(ppu_addr_q[12:0]);

	// One-screen mirroring, configured mirroring has no effect here
	assign ciram_a10 = one_scr;

endmodule

// File: map_066.sv
`timescale 1ns/1ps

module map_066 import map_pkg::*; (
	input logic clk,
	input logic rst,
	input logic reg_wr,
	input cpu_data_t reg_data,
	input cpu_addr_t cpu_addr_q,
	input ppu_addr_t ppu_addr_q,
	input logic mirror_v,
	output prg_addr_t prg_addr,
	output chr_addr_t chr_addr,
	output logic ciram_a10
);

	logic [1:0] prg_bank; // 32K PRG bank
	logic [1:0] chr_bank; // 8K CHR bank

	// Both banks come from the same byte
	always_ff @(posedge clk) begin
		if (rst) begin
			prg_bank <= '0;
			chr_bank <= '0;
		end else if (reg_wr) begin
			prg_bank <= reg_data[5:4];
			chr_bank <= reg_data[1:0];
		end
	end

	assign prg_addr = prg_addr_t'({prg_bank, cpu_addr_q[14:0]});
	assign chr_addr = chr_addr_t'({chr_bank, ppu_addr_q[12:0]});

	assign ciram_a10 = mirror_v ? ppu_addr_q[10] : ppu_addr_q[11];

endmodule

// File: map_hub.sv
`timescale 1ns/1ps

`include "map_consts.svh"

module map_hub import map_pkg::*; (
	input logic clk,
	input logic rst,
	input map_idx_t map_idx,
	input logic mirror_v,
	input cpu_addr_t cpu_addr_q,
	input ppu_addr_t ppu_addr_q,
	input prg_addr_t prg_002,
	input chr_addr_t chr_002,
	input logic a10_002,
	input prg_addr_t prg_007,
	input chr_addr_t chr_007,
	input logic a10_007,
	input prg_addr_t prg_066,
	input chr_addr_t chr_066,
	input logic a10_066,
	output prg_addr_t prg_addr,
	output chr_addr_t chr_addr,
	output logic ciram_a10
);

	prg_addr_t prg_nom;
	chr_addr_t chr_nom;
	logic a10_nom;

	prg_addr_t prg_sel;
	chr_addr_t chr_sel;
	logic a10_sel;

	// ~~~~~~~~~~~~~~~~~~~~ Fixed mapping
	assign prg_nom = prg_addr_t'(cpu_addr_q[14:0]);
	assign chr_nom = chr_addr_t'(ppu_addr_q[12:0]);
	assign a10_nom = mirror_v ? ppu_addr_q[10] : ppu_addr_q[11];

	// ~~~~~~~~~~~~~~~~~~~~ Core select
	always_comb begin
		case (map_idx)
			`MAP_UXROM: begin
				prg_sel = prg_002;
				chr_sel = chr_002;
				a10_sel = a10_002;
			end
			`MAP_AXROM: begin
				prg_sel = prg_007;
				chr_sel = chr_007;
				a10_sel = a10_007;
			end
			`MAP_GXROM: begin
				prg_sel = prg_066;
				chr_sel = chr_066;
				a10_sel = a10_066;
			end
			default: begin // Mapper 0 and unknown numbers
				prg_sel = prg_nom;
				chr_sel = chr_nom;
				a10_sel = a10_nom;
			end
		endcase
	end

	// Second pipeline stage
	always_ff @(posedge clk) begin
		if (rst) begin
			prg_addr <= '0;
			chr_addr <= '0;
			ciram_a10 <= 1'b0;
		end else begin
			prg_addr <= prg_sel;
			chr_addr <= chr_sel;
			ciram_a10 <= a10_sel;
		end
	end

endmodule

// File: cart_top.sv
`timescale 1ns/1ps

module cart_top import map_pkg::*; (
	input logic clk,
	input logic rst,
	input cpu_addr_t cpu_addr,
	input cpu_data_t cpu_data,
	input logic cpu_we,
	input ppu_addr_t ppu_addr,
	input map_idx_t map_idx,
	input logic mirror_v,
	output prg_addr_t prg_addr,
	output chr_addr_t chr_addr,
	output logic ciram_a10
);

	logic reg_wr;
	cpu_data_t reg_data;
	cpu_addr_t cpu_addr_q;
	ppu_addr_t ppu_addr_q;

	prg_addr_t prg_002, prg_007, prg_066;
	chr_addr_t chr_002, chr_007, chr_066;
	logic a10_002, a10_007, a10_066;

	bus_decode i_decode (
		.clk(clk), .rst(rst),
		.cpu_addr(cpu_addr), .cpu_data(cpu_data), .cpu_we(cpu_we), .ppu_addr(ppu_addr),
		.reg_wr(reg_wr), .reg_data(reg_data),
		.cpu_addr_q(cpu_addr_q), .ppu_addr_q(ppu_addr_q)
	);

	// ~~~~~~~~~~~~~~~~~~~~ Mapper cores
	map_002 i_m002 (
		.clk(clk), .rst(rst), .reg_wr(reg_wr), .reg_data(reg_data),
		.cpu_addr_q(cpu_addr_q), .ppu_addr_q(ppu_addr_q), .mirror_v(mirror_v),
		.prg_addr(prg_002), .chr_addr(chr_002), .ciram_a10(a10_002)
	);

	map_007 i_m007 (
		.clk(clk), .rst(rst), .reg_wr(reg_wr), .reg_data(reg_data),
		.cpu_addr_q(cpu_addr_q), .ppu_addr_q(ppu_addr_q),
		.prg_addr(prg_007), .chr_addr(chr_007), .ciram_a10(a10_007)
	);

	map_066 i_m066 (
		.clk(clk), .rst(rst), .reg_wr(reg_wr), .reg_data(reg_data),
		.cpu_addr_q(cpu_addr_q), .ppu_addr_q(ppu_addr_q), .mirror_v(mirror_v),
		.prg_addr(prg_066), .chr_addr(chr_066), .ciram_a10(a10_066)
	);

	map_hub i_hub (
		.clk(clk), .rst(rst), .map_idx(map_idx), .mirror_v(mirror_v),
		.cpu_addr_q(cpu_addr_q), .ppu_addr_q(ppu_addr_q),
		.prg_002(prg_002), .chr_002(chr_002), .a10_002(a10_002),
		.prg_007(prg_007), .chr_007(chr_007), .a10_007(a10_007),
		.prg_066(prg_066), .chr_066(chr_066), .a10_066(a10_066),
		.prg_addr(prg_addr), .chr_addr(chr_addr), .ciram_a10(ciram_a10)
	);

endmodule

// File: tb_checker.sv
`timescale 1ns/1ps

`include "map_consts.svh"

module tb_checker import map_pkg::*; (
	input logic clk,
	input logic rst,
	input cpu_addr_t cpu_addr,
	input cpu_data_t cpu_data,
	input logic cpu_we,
	input ppu_addr_t ppu_addr,
	input map_idx_t map_idx,
	input logic mirror_v,
	input logic track,
	input prg_addr_t prg_addr,
	input chr_addr_t chr_addr,
	input logic ciram_a10
);

	localparam int RES_W = `PRG_AW + `CHR_AW + 1;

	cpu_data_t bank_byte; // Last byte written to $8000-$FFFF
	logic wr_p1, wr_p2;
	cpu_data_t data_p1, data_p2;
	logic vld_p1, vld_p2; // Samples waiting for their result
	logic [RES_W-1:0] exp_p1, exp_p2;

	string test_name = "none";
	int total_checks = 0;
	int total_errs = 0;
	int base_checks = 0;
	int base_errs = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;

	// ~~~~~~~~~~~~~~~~~~~~ Reference model
	function automatic logic [RES_W-1:0] expect_map(input map_idx_t idx, input logic mv,
			input cpu_addr_t a, input ppu_addr_t p, input cpu_data_t bb);
		int unsigned prg;
		int unsigned chr;
		logic a10;
		prg = 32'(a[14:0]);
		chr = 32'(p[12:0]);
		a10 = mv ? p[10] : p[11];
		case (idx)
			`MAP_UXROM: begin
				if (a[14]) begin
					prg = 32'(`UX_LAST_BANK) * 32'd16384 + 32'(a[13:0]);
				end else begin
					prg = 32'(bb[4:0]) * 32'd16384 + 32'(a[13:0]);
				end
			end
			`MAP_AXROM: begin
				prg = 32'(bb[2:0]) * 32'd32768 + 32'(a[14:0]);
				a10 = bb[4]; // One-screen page
			end
			`MAP_GXROM: begin
				prg = 32'(bb[5:4]) * 32'd32768 + 32'(a[14:0]);
				chr = 32'(bb[1:0]) * 32'd8192 + 32'(p[12:0]);
			end
			default: begin
			end
		endcase
		return {prg[`PRG_AW-1:0], chr[`CHR_AW-1:0], a10};
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~ Compare
	always @(posedge clk) begin : compare
		logic [RES_W-1:0] got;
		if (rst) begin
			bank_byte = '0;
			wr_p1 = 1'b0;
			wr_p2 = 1'b0;
			vld_p1 = 1'b0;
			vld_p2 = 1'b0;
		end else begin
			got = {prg_addr, chr_addr, ciram_a10};
			if (vld_p2) begin
				total_checks++;
				if (got !== exp_p2) begin
					total_errs++;
					$display("mismatch %s: expected prg/chr/a10 %05h/%05h/%0b, actual %05h/%05h/%0b",
						test_name, exp_p2[RES_W-1:`CHR_AW+1], exp_p2[`CHR_AW:1], exp_p2[0],
						prg_addr, chr_addr, ciram_a10);
				end
			end
			// Write lands in time for the sample two edges later
			if (wr_p2) begin
				bank_byte = data_p2;
			end
			vld_p2 = vld_p1;
			exp_p2 = exp_p1;
			wr_p2 = wr_p1;
			data_p2 = data_p1;
			vld_p1 = track;
			exp_p1 = expect_map(map_idx, mirror_v, cpu_addr, ppu_addr, bank_byte);
			wr_p1 = cpu_we & cpu_addr[15];
			data_p1 = cpu_data;
		end
	end

	task automatic start_test(input string name);
		test_name = name;
		base_checks = total_checks;
		base_errs = total_errs;
	endtask

	task automatic finish_test();
		int checks;
		int errs;
		checks = total_checks - base_checks;
		errs = total_errs - base_errs;
		if (checks == 0) begin
			$display("test %s: failed, no outputs were compared", test_name);
			fail_cnt++;
		end else if (errs != 0) begin
			$display("test %s: failed, %0d of %0d checks wrong", test_name, errs, checks);
			fail_cnt++;
		end else begin
			$display("test %s: ok, %0d checks", test_name, checks);
			pass_cnt++;
		end
	endtask

endmodule

// File: tb_cart.sv
`timescale 1ns/1ps

`include "map_consts.svh"

module tb_cart import map_pkg::*; ();

	localparam int DRAIN_LIMIT = 50;

	logic clk;
	logic rst;
	cpu_addr_t cpu_addr;
	cpu_data_t cpu_data;
	logic cpu_we;
	ppu_addr_t ppu_addr;
	map_idx_t map_idx;
	logic mirror_v;
	logic track; // Cycles the checker follows
	prg_addr_t prg_addr;
	chr_addr_t chr_addr;
	logic ciram_a10;
	int timeouts;

	cart_top i_dut (
		.clk(clk), .rst(rst), .cpu_addr(cpu_addr), .cpu_data(cpu_data), .cpu_we(cpu_we),
		.ppu_addr(ppu_addr), .map_idx(map_idx), .mirror_v(mirror_v),
		.prg_addr(prg_addr), .chr_addr(chr_addr), .ciram_a10(ciram_a10)
	);

	tb_checker i_chk (
		.clk(clk), .rst(rst), .cpu_addr(cpu_addr), .cpu_data(cpu_data), .cpu_we(cpu_we),
		.ppu_addr(ppu_addr), .map_idx(map_idx), .mirror_v(mirror_v), .track(track),
		.prg_addr(prg_addr), .chr_addr(chr_addr), .ciram_a10(ciram_a10)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~ Bus drivers
	task automatic drive_bus(input logic we, input logic rom_area);
		logic [31:0] r;
		logic [31:0] s;
		r = $urandom;
		s = $urandom;
		@(negedge clk);
		cpu_we = we;
		cpu_addr = {we ? rom_area : r[31], r[14:0]}; // Writes pick their half
		cpu_data = s[7:0];
		ppu_addr = s[29:16];
	endtask

	task automatic apply_reset(input map_idx_t idx, input logic mv);
		@(negedge clk);
		rst = 1'b1;
		track = 1'b0;
		cpu_we = 1'b0;
		map_idx = idx; // Config only moves under reset
		mirror_v = mv;
		repeat (5) @(negedge clk);
		rst = 1'b0;
		track = 1'b1;
	endtask

	task automatic wait_drained();
		int n;
		@(negedge clk);
		track = 1'b0;
		cpu_we = 1'b0;
		n = 0;
		while ((i_chk.vld_p1 || i_chk.vld_p2) && n < DRAIN_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (n >= DRAIN_LIMIT) begin
			$display("timeout: checker still had samples pending after %0d cycles", DRAIN_LIMIT);
			timeouts++;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~ Tests
	task automatic run_test(input string name, input map_idx_t idx, input logic mv, input int n_wr);
		apply_reset(idx, mv);
		i_chk.start_test(name);
		repeat (n_wr) drive_bus(1'b1, 1'b1);
		repeat (3) drive_bus(1'b0, 1'b0); // Gap
		repeat (32) drive_bus(1'b0, 1'b0);
		wait_drained();
		i_chk.finish_test();
	endtask

	// Reads keep flowing across writes
	task automatic run_overlap(input string name, input map_idx_t idx, input logic mv);
		apply_reset(idx, mv);
		i_chk.start_test(name);
		repeat (6) drive_bus(1'b0, 1'b0);
		drive_bus(1'b1, 1'b1);
		repeat (4) drive_bus(1'b0, 1'b0);
		drive_bus(1'b1, 1'b1);
		drive_bus(1'b1, 1'b1);
		drive_bus(1'b1, 1'b0); // Ignored when below $8000
		repeat (8) drive_bus(1'b0, 1'b0);
		wait_drained();
		i_chk.finish_test();
	endtask

	initial begin
		void'($urandom(77));
		timeouts = 0;
		rst = 1'b1;
		track = 1'b0;
		cpu_addr = '0;
		cpu_data = '0;
		cpu_we = 1'b0;
		ppu_addr = '0;
		map_idx = `MAP_NROM;
		mirror_v = 1'b0;
		run_test("nrom_h", `MAP_NROM, 1'b0, 0);
		run_test("nrom_v", `MAP_NROM, 1'b1, 2);
		for (int k = 0; k < 4; k++) begin
			run_test($sformatf("uxrom_%0d", k), `MAP_UXROM, k[0], k);
			run_test($sformatf("axrom_%0d", k), `MAP_AXROM, k[0], k);
			run_test($sformatf("gxrom_%0d", k), `MAP_GXROM, k[1], k);
		end
		run_test("unknown_12", 8'd12, 1'b1, 3);
		run_overlap("uxrom_overlap", `MAP_UXROM, 1'b0);
		run_overlap("axrom_overlap", `MAP_AXROM, 1'b1);
		run_overlap("gxrom_overlap", `MAP_GXROM, 1'b1);
		$display("tests passed %0d, failed %0d, timeouts %0d",
			i_chk.pass_cnt, i_chk.fail_cnt, timeouts);
		if (i_chk.fail_cnt == 0 && timeouts == 0 && i_chk.pass_cnt > 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: filelist.f
+incdir+.
map_pkg.sv
bus_decode.sv
map_002.sv
map_007.sv
map_066.sv
map_hub.sv
cart_top.sv
tb_checker.sv
tb_cart.sv

// File: run.sh
#!/bin/sh
# Builds and runs the mapper testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -f filelist.f --top-module tb_cart -o tb_cart
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_cart > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
	exit 0
fi
exit 1
